//--- include/keypad_params.svh
`ifndef KEYPAD_PARAMS_SVH
`define KEYPAD_PARAMS_SVH

// clocks a row level must hold in a debounce state
// kept small for simulation, board builds override the top parameter
`define KEYPAD_DEBOUNCE_CYCLES 20

// scanner step interval, lets the column lines settle
`define KEYPAD_SCAN_DIV 3

// key event queue depth
`define KEYPAD_FIFO_DEPTH 8

`endif

//--- hw/keypad_scan_pkg.sv
package keypad_scan_pkg;

    // one captured keypad position
    // both patterns active low, exactly as seen on the pins
    typedef struct packed {
        logic [3:0] rows;
        logic [3:0] cols;
    } scan_coord_t;

    // one-hot scanner states
    typedef enum logic [7:0] {
        st_idle             = 8'b0000_0001,
        st_press_debounce   = 8'b0000_0010,
        st_col0             = 8'b0000_0100,
        st_col1             = 8'b0000_1000,
        st_col2             = 8'b0001_0000,
        st_col3             = 8'b0010_0000,
        // coordinate latched on entry
        st_read             = 8'b0100_0000,
        st_release_debounce = 8'b1000_0000
    } scan_state_t;

endpackage

//--- hw/keypad_event_pkg.sv
package keypad_event_pkg;

    // hex key code, 0-9 and A-F
    typedef logic [3:0] key_code_t;

    // codes standing in for the two symbol keys
    localparam key_code_t KEY_STAR = 4'he;
    localparam key_code_t KEY_HASH = 4'hf;

    // one decoded key press as queued for the host
    // coord kept alongside the code for diagnostics
    typedef struct packed {
        key_code_t                    code;
        keypad_scan_pkg::scan_coord_t coord;
    } key_event_t;

endpackage

//--- hw/row_sampler.sv
`timescale 1ns/10ps

module row_sampler (
    input  logic       clk,
    input  logic       rst_n,
    input  logic [3:0] row_in,
    output logic [3:0] rows_stable,
    output logic       rows_active
);

    // two-flop synchronizer on the row pins
    logic [3:0] sync_1;
    logic [3:0] sync_2;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sync_1      <= 4'hf;
            sync_2      <= 4'hf;
            rows_stable <= 4'hf;
            rows_active <= 1'b0;
        end else begin
            sync_1 <= row_in;
            sync_2 <= sync_1;
            // pass a pattern on only when two samples in a row agree
            // single-sample glitches never match and get filtered
            if (sync_1 == sync_2) begin
                rows_stable <= sync_2;
                rows_active <= (sync_2 != 4'hf);
            end
        end
    end

endmodule

//--- hw/keypad_scanner.sv
`timescale 1ns/10ps
`include "keypad_params.svh"

module keypad_scanner #(
    parameter int DEBOUNCE_CYCLES = `KEYPAD_DEBOUNCE_CYCLES
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic [3:0]                   rows_stable,
    input  logic                         rows_active,
    output logic [3:0]                   col_out,
    output logic                         coord_valid,
    output keypad_scan_pkg::scan_coord_t coord
);

    localparam int DIV_W = $clog2(`KEYPAD_SCAN_DIV + 1);
    localparam int DEB_W = $clog2(DEBOUNCE_CYCLES + 1);

    keypad_scan_pkg::scan_state_t state;
    keypad_scan_pkg::scan_state_t next_state;

    logic [DIV_W-1:0] div_cnt;
    logic [DEB_W-1:0] deb_cnt;
    logic             tick;
    logic             deb_hold;
    logic             deb_done;

    // divider runs 0..SCAN_DIV so a step outlasts the row sampler latency
    assign tick = (div_cnt == DIV_W'(`KEYPAD_SCAN_DIV));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            div_cnt <= '0;
        end else if (tick) begin
            div_cnt <= '0;
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    // level the current debounce state is waiting on
    always_comb begin
        case (state)
            keypad_scan_pkg::st_press_debounce:   deb_hold = rows_active;
            keypad_scan_pkg::st_release_debounce: deb_hold = !rows_active;
            default:                              deb_hold = 1'b0;
        endcase
    end

    assign deb_done = (deb_cnt == DEB_W'(DEBOUNCE_CYCLES));

    // restarts whenever the level breaks, saturates once done
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            deb_cnt <= '0;
        end else if (!deb_hold) begin
            deb_cnt <= '0;
        end else if (!deb_done) begin
            deb_cnt <= deb_cnt + 1'b1;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            keypad_scan_pkg::st_idle:
                if (rows_active) next_state = keypad_scan_pkg::st_press_debounce;
            keypad_scan_pkg::st_press_debounce:
                if (!rows_active)  next_state = keypad_scan_pkg::st_idle;
                else if (deb_done) next_state = keypad_scan_pkg::st_col0;
            keypad_scan_pkg::st_col0:
                if (rows_active) next_state = keypad_scan_pkg::st_read;
                else             next_state = keypad_scan_pkg::st_col1;
            keypad_scan_pkg::st_col1:
                if (rows_active) next_state = keypad_scan_pkg::st_read;
                else             next_state = keypad_scan_pkg::st_col2;
            keypad_scan_pkg::st_col2:
                if (rows_active) next_state = keypad_scan_pkg::st_read;
                else             next_state = keypad_scan_pkg::st_col3;
            keypad_scan_pkg::st_col3:
                if (rows_active) next_state = keypad_scan_pkg::st_read;
                else             next_state = keypad_scan_pkg::st_idle;
            keypad_scan_pkg::st_read:
                next_state = keypad_scan_pkg::st_release_debounce;
            keypad_scan_pkg::st_release_debounce:
                if (deb_done) next_state = keypad_scan_pkg::st_idle;
            default:
                next_state = keypad_scan_pkg::st_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= keypad_scan_pkg::st_idle;
        end else if (tick) begin
            state <= next_state;
        end
    end

    // column drive follows the state being entered
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            col_out <= 4'b0000;
        end else if (tick) begin
            case (next_state)
                keypad_scan_pkg::st_col0: col_out <= 4'b0111;
                keypad_scan_pkg::st_col1: col_out <= 4'b1011;
                keypad_scan_pkg::st_col2: col_out <= 4'b1101;
                keypad_scan_pkg::st_col3: col_out <= 4'b1110;
                // hold the found column through the capture step
                keypad_scan_pkg::st_read: col_out <= col_out;
                default:                  col_out <= 4'b0000;
            endcase
        end
    end

    // capture rows and the column that pulled them low
    always_ff @(posedge clk) begin
        if (tick && next_state == keypad_scan_pkg::st_read) begin
            coord.rows <= rows_stable;
            coord.cols <= col_out;
        end
    end

    // one strobe per press, at the end of the release debounce
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            coord_valid <= 1'b0;
        end else begin
            coord_valid <= tick && (state == keypad_scan_pkg::st_release_debounce)
                           && (next_state == keypad_scan_pkg::st_idle);
        end
    end

endmodule

//--- hw/key_decoder.sv
`timescale 1ns/10ps

module key_decoder (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           coord_valid,
    input  keypad_scan_pkg::scan_coord_t   coord,
    output logic                           event_valid,
    output keypad_event_pkg::key_event_t   event_data
);

    // {found, index of the single low bit}
    function automatic logic [2:0] low_index(input logic [3:0] pattern);
        case (pattern)
            4'b1110: return 3'b100;
            4'b1101: return 3'b101;
            4'b1011: return 3'b110;
            4'b0111: return 3'b111;
            default: return 3'b000;
        endcase
    endfunction

    // keypad face, row by row
    function automatic keypad_event_pkg::key_code_t code_of(input logic [1:0] row,
                                                            input logic [1:0] col);
        case ({row, col})
            4'h0: return 4'h1;
            4'h1: return 4'h2;
            4'h2: return 4'h3;
            4'h3: return 4'ha;
            4'h4: return 4'h4;
            4'h5: return 4'h5;
            4'h6: return 4'h6;
            4'h7: return 4'hb;
            4'h8: return 4'h7;
            4'h9: return 4'h8;
            4'ha: return 4'h9;
            4'hb: return 4'hc;
            4'hc: return keypad_event_pkg::KEY_STAR;
            4'hd: return 4'h0;
            4'he: return keypad_event_pkg::KEY_HASH;
            default: return 4'hd;
        endcase
    endfunction

    logic [2:0] row_sel;
    logic [2:0] col_sel;
    logic [1:0] col_idx;

    assign row_sel = low_index(coord.rows);
    assign col_sel = low_index(coord.cols);
    // column 0 drives the top col_out bit low
    assign col_idx = 2'd3 - col_sel[1:0];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            event_valid <= 1'b0;
        end else begin
            // more than one low bit on either side means rollover, drop it
            event_valid <= coord_valid && row_sel[2] && col_sel[2];
        end
    end

    always_ff @(posedge clk) begin
        if (coord_valid) begin
            event_data.code  <= code_of(row_sel[1:0], col_idx);
            event_data.coord <= coord;
        end
    end

endmodule

//--- hw/key_fifo.sv
`timescale 1ns/10ps
`include "keypad_params.svh"

module key_fifo #(
    parameter int DEPTH = `KEYPAD_FIFO_DEPTH
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         event_valid,
    input  keypad_event_pkg::key_event_t event_data,
    input  logic                         key_rd,
    output logic                         key_avail,
    output keypad_event_pkg::key_event_t key_event,
    output logic                         overflow
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    keypad_event_pkg::key_event_t mem [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             full;
    logic             push;
    logic             pop;

    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign key_avail = (count != '0);
    assign full      = (count == CNT_W'(DEPTH));
    // reads on an empty queue are ignored
    assign pop       = key_rd && key_avail;
    // a pop in the same cycle frees the slot for a push into a full queue
    assign push      = event_valid && (!full || pop);

    // head entry shown without a read cycle
    assign key_event = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= event_data;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // sticky until reset, a lost key stays visible to the host
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            overflow <= 1'b0;
        end else if (event_valid && full && !pop) begin
            overflow <= 1'b1;
        end
    end

endmodule

//--- hw/keypad_ctrl.sv
`timescale 1ns/10ps
`include "keypad_params.svh"

module keypad_ctrl #(
    parameter int DEBOUNCE_CYCLES = `KEYPAD_DEBOUNCE_CYCLES,
    parameter int FIFO_DEPTH      = `KEYPAD_FIFO_DEPTH
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic [3:0]                   row_in,
    output logic [3:0]                   col_out,
    output logic                         key_avail,
    output keypad_event_pkg::key_event_t key_event,
    input  logic                         key_rd,
    output logic                         overflow
);

    logic [3:0]                   rows_stable;
    logic                         rows_active;
    logic                         coord_valid;
    keypad_scan_pkg::scan_coord_t coord;
    logic                         event_valid;
    keypad_event_pkg::key_event_t event_data;

    // pins to filtered row levels
    row_sampler i_sampler (
        .clk         (clk),
        .rst_n       (rst_n),
        .row_in      (row_in),
        .rows_stable (rows_stable),
        .rows_active (rows_active)
    );

    keypad_scanner #(
        .DEBOUNCE_CYCLES (DEBOUNCE_CYCLES)
    ) i_scanner (
        .clk         (clk),
        .rst_n       (rst_n),
        .rows_stable (rows_stable),
        .rows_active (rows_active),
        .col_out     (col_out),
        .coord_valid (coord_valid),
        .coord       (coord)
    );

    key_decoder i_decoder (
        .clk         (clk),
        .rst_n       (rst_n),
        .coord_valid (coord_valid),
        .coord       (coord),
        .event_valid (event_valid),
        .event_data  (event_data)
    );

    // host side queue
    key_fifo #(
        .DEPTH (FIFO_DEPTH)
    ) i_fifo (
        .clk         (clk),
        .rst_n       (rst_n),
        .event_valid (event_valid),
        .event_data  (event_data),
        .key_rd      (key_rd),
        .key_avail   (key_avail),
        .key_event   (key_event),
        .overflow    (overflow)
    );

endmodule

//--- test/keypad_ctrl_assertions.sv
`timescale 1ns/10ps

module keypad_ctrl_assertions (
    input logic       clk,
    input logic       rst_n,
    input logic [3:0] col_out,
    input logic       coord_valid,
    input logic       event_valid,
    input logic       key_avail,
    input logic       overflow
);

    // number of failed properties
    int fail_count = 0;

    // idle drive or exactly one column pulled low
    assert property (@(posedge clk) disable iff (!rst_n)
        col_out inside {4'b0000, 4'b0111, 4'b1011, 4'b1101, 4'b1110})
        else begin
            fail_count++;
            $error("col_out shows an illegal column pattern");
        end

    assert property (@(posedge clk) disable iff (!rst_n) coord_valid |=> !coord_valid)
        else begin
            fail_count++;
            $error("coord_valid held high for two cycles");
        end

    assert property (@(posedge clk) disable iff (!rst_n) event_valid |=> !event_valid)
        else begin
            fail_count++;
            $error("event_valid held high for two cycles");
        end

    // sticky flag that only reset clears
    assert property (@(posedge clk) (rst_n && overflow) |=> overflow)
        else begin
            fail_count++;
            $error("overflow fell while out of reset");
        end

    assert property (@(posedge clk) !rst_n |=> !key_avail)
        else begin
            fail_count++;
            $error("key_avail high right after reset");
        end

endmodule

bind keypad_ctrl keypad_ctrl_assertions i_assertions (
    .clk         (clk),
    .rst_n       (rst_n),
    .col_out     (col_out),
    .coord_valid (coord_valid),
    .event_valid (event_valid),
    .key_avail   (key_avail),
    .overflow    (overflow)
);

//--- test/keypad_ctrl_tb.sv
`timescale 1ns/10ps
`include "keypad_params.svh"

module keypad_ctrl_tb;

    localparam int EVENT_WINDOW = 200;
    localparam int AVAIL_WINDOW = 20;

    logic                         clk;
    logic                         rst_n;
    logic [3:0]                   row_in;
    logic [3:0]                   col_out;
    logic                         key_avail;
    keypad_event_pkg::key_event_t key_event;
    logic                         key_rd;
    logic                         overflow;

    // keypad model state
    logic       key_down;
    logic       dual_row;
    logic [1:0] key_row;
    logic [1:0] key_col;

    int          errors;
    int          checks;
    logic [31:0] rng;

    // pattern table with one entry per data line
    int         pat_row[$];
    int         pat_col[$];
    int         pat_hold[$];
    int         pat_mode[$];
    bit         pat_none[$];
    logic [3:0] pat_code[$];
    // entries that produce a key
    int         valid_idx[$];
    int         pend_idx[$];

    keypad_ctrl #(
        .DEBOUNCE_CYCLES (`KEYPAD_DEBOUNCE_CYCLES),
        .FIFO_DEPTH      (`KEYPAD_FIFO_DEPTH)
    ) i_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .row_in    (row_in),
        .col_out   (col_out),
        .key_avail (key_avail),
        .key_event (key_event),
        .key_rd    (key_rd),
        .overflow  (overflow)
    );

    always #50 clk = ~clk;

    // a pressed key shorts its row to its column line
    always_comb begin
        row_in = 4'hf;
        if (key_down && !col_out[3 - key_col]) begin
            row_in[key_row] = 1'b0;
            if (dual_row) begin
                row_in[key_row + 2'd1] = 1'b0;
            end
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        assert (actual === expected) else begin
            $display("CHECK FAILED %s expected %0h got %0h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic report_error(input string what);
        $display("ERROR: %s", what);
        errors++;
    endtask

    // inputs change 10 ns after the rising edge
    task automatic step();
        @(posedge clk);
        #10;
    endtask

    task automatic idle(input int n);
        repeat (n) step();
    endtask

    task automatic random_gap();
        rng = xorshift(rng);
        idle(rng % 8 + 2);
    endtask

    task automatic press_key(input int idx);
        int i;
        key_row  = 2'(pat_row[idx]);
        key_col  = 2'(pat_col[idx]);
        dual_row = (pat_mode[idx] == 2);
        if (pat_mode[idx] == 1) begin
            // one-cycle toggles so no two samples in a row agree
            for (i = 0; i < pat_hold[idx]; i++) begin
                key_down = !key_down;
                step();
            end
        end else begin
            key_down = 1'b1;
            idle(pat_hold[idx]);
        end
        key_down = 1'b0;
        dual_row = 1'b0;
    endtask

    task automatic await_event(input bit expect_one, output bit seen);
        int waited;
        seen   = 1'b0;
        waited = 0;
        while (!seen && waited < EVENT_WINDOW) begin
            seen = i_dut.event_valid;
            if (!seen) begin
                step();
                waited++;
            end
        end
        if (expect_one && !seen) begin
            report_error("timed out waiting for a key event after release");
        end
    endtask

    task automatic read_key(input int idx);
        int         waited;
        logic [3:0] exp_rows;
        logic [3:0] exp_cols;
        waited = 0;
        while (!key_avail && waited < AVAIL_WINDOW) begin
            step();
            waited++;
        end
        if (!key_avail) begin
            report_error("timed out waiting for key_avail");
        end else begin
            // one low bit per pattern with column c on col_out bit 3-c
            exp_rows = ~(4'b0001 << pat_row[idx]);
            exp_cols = ~(4'b1000 >> pat_col[idx]);
            check_value("key_event.code", pat_code[idx], key_event.code);
            check_value("key_event.coord.rows", exp_rows, key_event.coord.rows);
            check_value("key_event.coord.cols", exp_cols, key_event.coord.cols);
            key_rd = 1'b1;
            step();
            key_rd = 1'b0;
        end
    endtask

    task automatic run_pattern(input int idx);
        bit seen;
        random_gap();
        press_key(idx);
        await_event(!pat_none[idx], seen);
        if (pat_none[idx]) begin
            check_value("event_valid", 0, seen);
            check_value("key_avail", 0, key_avail);
        end else if (seen) begin
            read_key(idx);
        end
    endtask

    task automatic load_patterns();
        int         fd;
        int         n;
        int         r;
        int         c;
        int         hold;
        int         mode;
        string      line;
        string      exp_txt;
        logic [3:0] code;
        fd = $fopen("test/keypad_patterns.txt", "r");
        if (fd == 0) begin
            report_error("could not open test/keypad_patterns.txt");
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (n > 0 && line.len() > 1 && line[0] != "#") begin
                n = $sscanf(line, "%d %d %d %d %s", r, c, hold, mode, exp_txt);
                if (n == 5) begin
                    pat_row.push_back(r);
                    pat_col.push_back(c);
                    pat_hold.push_back(hold);
                    pat_mode.push_back(mode);
                    code = 4'h0;
                    if (exp_txt == "none") begin
                        pat_none.push_back(1'b1);
                    end else begin
                        n = $sscanf(exp_txt, "%h", code);
                        pat_none.push_back(1'b0);
                        valid_idx.push_back(pat_row.size() - 1);
                    end
                    pat_code.push_back(code);
                end
            end
        end
        $fclose(fd);
    endtask

    initial begin
        int k;
        int idx;
        int reads;
        bit seen;
        clk      = 1'b0;
        rst_n    = 1'b0;
        key_rd   = 1'b0;
        key_down = 1'b0;
        dual_row = 1'b0;
        key_row  = 2'd0;
        key_col  = 2'd0;
        errors   = 0;
        checks   = 0;
        rng      = 32'd9;
        idle(8);
        rst_n = 1'b1;
        step();
        check_value("col_out", 4'b0000, col_out);
        check_value("key_avail", 0, key_avail);
        check_value("overflow", 0, overflow);

        load_patterns();
        for (k = 0; k < pat_row.size(); k++) begin
            run_pattern(k);
        end

        // nine presses with no reads so the ninth finds the queue full
        if (valid_idx.size() < 9) begin
            report_error("pattern file holds fewer than nine key presses");
        end else begin
            for (k = 0; k < 9; k++) begin
                random_gap();
                press_key(valid_idx[k]);
                await_event(1'b1, seen);
            end
            idle(2);
            check_value("overflow", 1, overflow);
            check_value("key_avail", 1, key_avail);
            for (k = 0; k < 8; k++) begin
                read_key(valid_idx[k]);
            end
            check_value("key_avail", 0, key_avail);
        end

        // presses and reads mixed with random gaps
        if (valid_idx.size() > 0) begin
            for (k = 0; k < 12; k++) begin
                rng = xorshift(rng);
                idx = valid_idx[rng % valid_idx.size()];
                random_gap();
                press_key(idx);
                await_event(1'b1, seen);
                pend_idx.push_back(idx);
                rng = xorshift(rng);
                reads = rng % 3;
                while (reads > 0 && pend_idx.size() > 0) begin
                    read_key(pend_idx.pop_front());
                    reads--;
                end
            end
            while (pend_idx.size() > 0) begin
                read_key(pend_idx.pop_front());
            end
            check_value("key_avail", 0, key_avail);
        end

        errors += i_dut.i_assertions.fail_count;
        $display("summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

//--- keypad_ctrl.f
+incdir+include
hw/keypad_scan_pkg.sv
hw/keypad_event_pkg.sv
hw/row_sampler.sv
hw/keypad_scanner.sv
hw/key_decoder.sv
hw/key_fifo.sv
hw/keypad_ctrl.sv
test/keypad_ctrl_assertions.sv
test/keypad_ctrl_tb.sv

//--- Bender.yml
package:
  name: keypad_ctrl

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hw/keypad_scan_pkg.sv
      - hw/keypad_event_pkg.sv
      - hw/row_sampler.sv
      - hw/keypad_scanner.sv
      - hw/key_decoder.sv
      - hw/key_fifo.sv
      - hw/keypad_ctrl.sv
  - target: test
    include_dirs:
      - include
    files:
      - test/keypad_ctrl_assertions.sv
      - test/keypad_ctrl_tb.sv

//--- test/keypad_patterns.txt
# row col hold mode expected
# mode 0 clean press, 1 glitch burst, 2 also presses the next row down; expected is hex or none
0 0 70 0 1
0 1 70 0 2
0 2 70 0 3
0 3 70 0 a
1 0 70 0 4
1 1 70 0 5
1 2 70 0 6
1 3 70 0 b
2 1 10 0 none
2 0 70 0 7
2 1 70 0 8
2 2 70 0 9
2 3 70 0 c
3 2 8 1 none
3 0 70 0 e
3 1 70 0 0
3 2 70 0 f
3 3 70 0 d
1 2 70 2 none
0 3 12 0 none
